// ==== list.f ====
+incdir+.
fp_pkg.sv
fp_stage_if.sv
fp_mul_ctrl.sv
fp_unpack.sv
fp_mant_mul.sv
fp_pack.sv
fp_mul_top.sv
tb_fp_mul.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the multiplier testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_fp_mul -o tb_fp_mul

out="$(./obj_dir/tb_fp_mul)"
echo "$out"

if grep -qxF "Finished with no errors" <<< "$out"; then
  exit 0
else
  exit 1
fi

// ==== tb_fp_mul_model.svh ====
// reference model for the multiply testbench
// truncating single-precision product with nan, infinity and zero
// special cases, plus the random generator and operand builders
`ifndef TB_FP_MUL_MODEL_SVH
`define TB_FP_MUL_MODEL_SVH

// ========================================
// random numbers
// ========================================
// 32-bit linear congruential step, state lives in the testbench
function automatic logic [31:0] rand32();
  rng_state = rng_state * 32'd1664525 + 32'd1013904223;
  return rng_state;
endfunction

// assemble a word from its fields
function automatic logic [31:0] make_fp(input logic s, input logic [7:0] e,
                                        input logic [22:0] m);
  return {s, e, m};
endfunction

// normal operand, exponent in 64..190 so that any product stays in range
function automatic logic [31:0] rand_normal();
  logic [31:0] r1;
  logic [31:0] r2;
  logic [7:0]  ex;
  r1 = rand32();
  r2 = rand32();
  // upper lcg bits are the better ones
  ex = 8'd64 + 8'(r1[23:16] % 8'd127);
  return {r1[31], ex, r2[31:9]};
endfunction

// ========================================
// expected result
// ========================================
function automatic logic [31:0] ref_mul(input fp_pkg::opcode_e op, input logic [31:0] x,
                                        input logic [31:0] y_in);
  logic [31:0] y;
  logic        sgn;
  logic        x_nan, y_nan, x_inf, y_inf, x_zero, y_zero;
  int          ex, ey, e;
  logic [47:0] prod;
  logic [22:0] mant;
  // square ignores the second operand
  y      = (op == fp_pkg::op_square) ? x : y_in;
  ex     = {24'd0, x[30:23]};
  ey     = {24'd0, y[30:23]};
  x_nan  = (ex == 255) && (x[22:0] != 23'd0);
  y_nan  = (ey == 255) && (y[22:0] != 23'd0);
  x_inf  = (ex == 255) && (x[22:0] == 23'd0);
  y_inf  = (ey == 255) && (y[22:0] == 23'd0);
  // subnormals count as zero
  x_zero = (ex == 0);
  y_zero = (ey == 0);
  sgn    = x[31] ^ y[31];
  if (op == fp_pkg::op_neg_mul) sgn = ~sgn;
  else if (op == fp_pkg::op_abs_mul) sgn = 1'b0;
  // nan words pass through untouched, a first
  if (x_nan) return x;
  if (y_nan) return y;
  if ((x_inf && y_zero) || (y_inf && x_zero)) return fp_pkg::QNAN;
  if (x_inf || y_inf) return {sgn, 8'hff, 23'd0};
  if (x_zero || y_zero) return {sgn, 31'd0};
  prod = {24'd0, 1'b1, x[22:0]} * {24'd0, 1'b1, y[22:0]};
  e    = ex + ey - 127;
  // product in [1,4), drop the low bits without rounding
  if (prod[47]) begin
    e    = e + 1;
    mant = prod[46:24];
  end else begin
    mant = prod[45:23];
  end
  if (e >= 255) return {sgn, 8'hff, 23'd0};
  if (e <= 0) return {sgn, 31'd0};
  return {sgn, e[7:0], mant};
endfunction

`endif

// ==== tb_fp_mul.sv ====
// testbench for the pipelined floating-point multiplier
// random and directed operands, expected words queued at each start
// and compared at each done, three cycles of latency checked too
`timescale 1ns/1ps
`default_nettype none

module tb_fp_mul;

  localparam int N_RAND      = 300;
  localparam int N_PAIRS     = 20;
  localparam int N_SPECIAL   = 12;
  localparam int N_RANGE     = 12;
  localparam int N_GAP       = 40;
  localparam int MAX_GAP     = 4;
  localparam int RST_CYCLES  = 16;
  localparam int N_TESTS     = 5;
  // every op, every idle slot, both resets, drain per test, margin
  localparam int CYCLE_LIMIT = N_RAND + 4 * N_PAIRS + N_SPECIAL + N_RANGE
                             + N_GAP * (1 + MAX_GAP) + 2 * RST_CYCLES + 3 * N_TESTS + 50;

  logic            clk;
  logic            reset;
  logic            start;
  fp_pkg::opcode_e opcode;
  logic [31:0]     a;
  logic [31:0]     b;
  logic [31:0]     result;
  logic            done;

  logic [31:0] rng_state;
  logic [31:0] exp_q[$];
  int          cyc_q[$];
  logic [31:0] exp_word;
  int          start_cyc;
  int          cycle = 0;
  int          errors, n_issued, n_checked, test_num, ops_base, err_base, post_rst;
  logic        rst_prev;

  `include "tb_fp_mul_model.svh"

  fp_mul_top i_dut (
    .clk    (clk),
    .reset  (reset),
    .start  (start),
    .opcode (opcode),
    .a      (a),
    .b      (b),
    .result (result),
    .done   (done)
  );

  always #50 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("timeout: run stopped after %0d cycles", cycle);
      $display("Finished with errors");
      $finish;
    end
  end

  // ========================================
  // scoreboard, sampled on the falling edge
  // ========================================
  always @(negedge clk) begin
    // outputs must be quiet once reset has been seen by a clock edge
    if ((reset && rst_prev) || (!reset && post_rst != 0)) begin
      if (done !== 1'b0) begin
        $display("error at %0t: done got %b expected 0", $time, done);
        errors++;
      end
      if (result !== 32'd0) begin
        $display("error at %0t: result got %h expected %h", $time, result, 32'd0);
        errors++;
      end
      if (!reset) post_rst--;
    end
    if (done === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("done pulse at %0t with no operation outstanding", $time);
        errors++;
      end else begin
        exp_word  = exp_q.pop_front();
        start_cyc = cyc_q.pop_front();
        n_checked++;
        if (result !== exp_word) begin
          $display("error at %0t: result got %h expected %h", $time, result, exp_word);
          errors++;
        end
        if (cycle - start_cyc != 3) begin
          $display("result at %0t came %0d cycles after start instead of 3", $time,
                   cycle - start_cyc);
          errors++;
        end
      end
    end
    // reset cancels whatever is in flight
    if (reset) begin
      exp_q.delete();
      cyc_q.delete();
      post_rst = 3;
    end else if (start) begin
      exp_q.push_back(ref_mul(opcode, a, b));
      cyc_q.push_back(cycle);
    end
    rst_prev = reset;
  end

  // ========================================
  // stimulus helpers
  // ========================================
  task automatic issue_op(input fp_pkg::opcode_e op, input logic [31:0] x, input logic [31:0] y);
    @(posedge clk);
    start  <= 1'b1;
    opcode <= op;
    a      <= x;
    b      <= y;
    n_issued++;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      start <= 1'b0;
    end
  endtask

  // wait for every outstanding done, bounded
  task automatic drain_pipe();
    int w;
    w = 0;
    idle_cycles(1);
    while (exp_q.size() != 0 && w < 8) begin
      @(posedge clk);
      w++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d operations never produced a done", exp_q.size());
      errors++;
      exp_q.delete();
      cyc_q.delete();
    end
  endtask

  task automatic report_test(input string name);
    test_num++;
    $display("test %0d %s: %0d ops, %0d errors", test_num, name, n_issued - ops_base,
             errors - err_base);
    ops_base = n_issued;
    err_base = errors;
  endtask

  // ========================================
  // test sequence
  // ========================================
  initial begin
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] r;
    clk       = 1'b0;
    reset     = 1'b1;
    start     = 1'b0;
    opcode    = fp_pkg::op_mul;
    a         = 32'd0;
    b         = 32'd0;
    rng_state = 32'h762e;
    errors    = 0;
    n_issued  = 0;
    n_checked = 0;
    test_num  = 0;
    ops_base  = 0;
    err_base  = 0;
    post_rst  = 0;
    rst_prev  = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    reset <= 1'b0;

    // back-to-back normal products
    for (int i = 0; i < N_RAND; i++) begin
      issue_op(fp_pkg::op_mul, rand_normal(), rand_normal());
    end
    drain_pipe();
    report_test("random multiply");

    // one operand pair under every opcode
    for (int i = 0; i < N_PAIRS; i++) begin
      x = rand_normal();
      y = rand_normal();
      issue_op(fp_pkg::op_mul, x, y);
      issue_op(fp_pkg::op_square, x, y);
      issue_op(fp_pkg::op_neg_mul, x, y);
      issue_op(fp_pkg::op_abs_mul, x, y);
    end
    drain_pipe();
    report_test("opcode variants");

    // nan, infinity and zero operands
    issue_op(fp_pkg::op_mul, 32'h7fc12345, rand_normal());
    issue_op(fp_pkg::op_mul, rand_normal(), 32'hffa00001);
    issue_op(fp_pkg::op_mul, 32'h7f800abc, 32'hffc00000);
    issue_op(fp_pkg::op_mul, 32'h7f800000, 32'hff812345);
    issue_op(fp_pkg::op_abs_mul, 32'hffc00001, 32'h3f800000);
    issue_op(fp_pkg::op_mul, 32'h7f800000, make_fp(1'b1, 8'd130, 23'h123456));
    issue_op(fp_pkg::op_neg_mul, 32'hff800000, make_fp(1'b1, 8'd100, 23'h0));
    issue_op(fp_pkg::op_mul, 32'h7f800000, 32'h00000000);
    issue_op(fp_pkg::op_mul, 32'h80000000, 32'hff800000);
    issue_op(fp_pkg::op_mul, 32'h80000000, make_fp(1'b0, 8'd140, 23'h7abcde));
    issue_op(fp_pkg::op_square, 32'hff800000, 32'h00000000);
    issue_op(fp_pkg::op_abs_mul, 32'h00000000, 32'hbf800000);
    drain_pipe();
    report_test("special operands");

    // overflow, underflow and flushed subnormals around the limits
    issue_op(fp_pkg::op_mul, make_fp(1'b0, 8'd200, 23'h1234), make_fp(1'b1, 8'd200, 23'h0));
    issue_op(fp_pkg::op_neg_mul, make_fp(1'b0, 8'd220, 23'h0), make_fp(1'b0, 8'd180, 23'h0));
    issue_op(fp_pkg::op_mul, make_fp(1'b0, 8'd191, 23'h0), make_fp(1'b0, 8'd191, 23'h0));
    issue_op(fp_pkg::op_mul, make_fp(1'b1, 8'd190, 23'h7fffff), make_fp(1'b0, 8'd191, 23'h7fffff));
    issue_op(fp_pkg::op_mul, make_fp(1'b0, 8'd190, 23'h0), make_fp(1'b0, 8'd191, 23'h0));
    issue_op(fp_pkg::op_mul, make_fp(1'b1, 8'd20, 23'h55aa), make_fp(1'b0, 8'd50, 23'h0));
    issue_op(fp_pkg::op_mul, make_fp(1'b0, 8'd63, 23'h0), make_fp(1'b0, 8'd64, 23'h0));
    issue_op(fp_pkg::op_mul, make_fp(1'b0, 8'd63, 23'h7fffff), make_fp(1'b1, 8'd64, 23'h7fffff));
    issue_op(fp_pkg::op_mul, make_fp(1'b1, 8'd0, 23'h12345), rand_normal());
    issue_op(fp_pkg::op_mul, rand_normal(), make_fp(1'b0, 8'd0, 23'h7fffff));
    issue_op(fp_pkg::op_square, make_fp(1'b1, 8'd10, 23'h0), 32'h0);
    issue_op(fp_pkg::op_abs_mul, make_fp(1'b1, 8'd240, 23'h0), make_fp(1'b0, 8'd240, 23'h0));
    drain_pipe();
    report_test("range limits");

    // random idle gaps, then a reset with operations in flight
    for (int i = 0; i < N_GAP; i++) begin
      issue_op(fp_pkg::op_mul, rand_normal(), rand_normal());
      r = rand32();
      idle_cycles(int'(r[31:29]) % (MAX_GAP + 1));
    end
    drain_pipe();
    for (int i = 0; i < 3; i++) begin
      issue_op(fp_pkg::op_mul, rand_normal(), rand_normal());
    end
    @(posedge clk);
    start <= 1'b0;
    reset <= 1'b1;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    idle_cycles(4);
    drain_pipe();
    report_test("gaps and reset");

    $display("%0d operations issued, %0d checked, %0d errors", n_issued, n_checked, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== fp_mul_top.sv ====
// pipelined floating-point multiply unit
// three registered stages (unpack, mantissa product, pack) under a
// small control block, result and done three cycles after start
`timescale 1ns/1ps
`default_nettype none

module fp_mul_top #(
  parameter int BIT_WIDTH = fp_pkg::SP_BIT_WIDTH,
  parameter int E_WIDTH   = fp_pkg::SP_E_WIDTH,
  parameter int M_WIDTH   = fp_pkg::SP_M_WIDTH
) (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 start,
  input  wire fp_pkg::opcode_e      opcode,
  input  wire logic [BIT_WIDTH-1:0] a,
  input  wire logic [BIT_WIDTH-1:0] b,
  output logic [BIT_WIDTH-1:0]      result,
  output logic                      done
);

  // control to datapath strobes
  logic               sel_square;
  logic               load_s1;
  logic               load_s2;
  logic               load_s3;
  fp_pkg::sign_mode_e sign_mode;

  // ========================================
  // stage links
  // ========================================
  fp_unpacked_if #(.BIT_WIDTH(BIT_WIDTH), .E_WIDTH(E_WIDTH), .M_WIDTH(M_WIDTH)) unp_if ();
  fp_product_if  #(.BIT_WIDTH(BIT_WIDTH), .E_WIDTH(E_WIDTH), .M_WIDTH(M_WIDTH)) prod_if ();

  fp_mul_ctrl i_ctrl (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .opcode     (opcode),
    .sel_square (sel_square),
    .load_s1    (load_s1),
    .load_s2    (load_s2),
    .load_s3    (load_s3),
    .sign_mode  (sign_mode),
    .done       (done)
  );

  // ========================================
  // datapath stages
  // ========================================
  fp_unpack #(.BIT_WIDTH(BIT_WIDTH), .E_WIDTH(E_WIDTH), .M_WIDTH(M_WIDTH)) i_unpack (
    .clk        (clk),
    .reset      (reset),
    .a          (a),
    .b          (b),
    .sel_square (sel_square),
    .load       (load_s1),
    .u          (unp_if.src)
  );

  fp_mant_mul #(.BIT_WIDTH(BIT_WIDTH), .E_WIDTH(E_WIDTH), .M_WIDTH(M_WIDTH)) i_mant_mul (
    .clk   (clk),
    .reset (reset),
    .load  (load_s2),
    .u     (unp_if.dst),
    .p     (prod_if.src)
  );

  fp_pack #(.BIT_WIDTH(BIT_WIDTH), .E_WIDTH(E_WIDTH), .M_WIDTH(M_WIDTH)) i_pack (
    .clk       (clk),
    .reset     (reset),
    .load      (load_s3),
    .sign_mode (sign_mode),
    .p         (prod_if.dst),
    .result    (result)
  );

endmodule

`default_nettype wire

// ==== fp_pack.sv ====
// stage three of the multiplier
// normalizes and truncates the product, clamps the exponent range,
// resolves nan, infinity and zero operands and applies the sign mode
`timescale 1ns/1ps
`default_nettype none

module fp_pack #(
  parameter int BIT_WIDTH = fp_pkg::SP_BIT_WIDTH,
  parameter int E_WIDTH   = fp_pkg::SP_E_WIDTH,
  parameter int M_WIDTH   = fp_pkg::SP_M_WIDTH
) (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire logic                load,
  input  wire fp_pkg::sign_mode_e  sign_mode,
  fp_product_if.dst                p,
  output logic [BIT_WIDTH-1:0]     result
);

  // all-ones exponent is the first value that no longer fits
  localparam logic signed [E_WIDTH+1:0] exp_ones = {2'b00, {E_WIDTH{1'b1}}};
  // canonical quiet nan taken from the package word for single precision
  localparam logic [BIT_WIDTH-1:0] qnan_word = (BIT_WIDTH == 32) ?
    fp_pkg::QNAN[BIT_WIDTH-1:0] :
    {1'b0, {E_WIDTH{1'b1}}, 1'b1, {(M_WIDTH-1){1'b0}}};

  // ========================================
  // normalize
  // ========================================
  logic                       prod_top;
  logic signed [E_WIDTH+1:0]  exp_norm;
  logic [M_WIDTH-1:0]         mant_norm;
  logic                       exp_over;
  logic                       exp_under;

  // product lies in [1,4) so a set top bit means a shift right by one
  assign prod_top  = p.prod[2*M_WIDTH+1];
  assign exp_norm  = p.exp_sum + $signed({{(E_WIDTH+1){1'b0}}, prod_top});
  // low bits dropped with no rounding
  assign mant_norm = prod_top ? p.prod[2*M_WIDTH:M_WIDTH+1] : p.prod[2*M_WIDTH-1:M_WIDTH];

  assign exp_over  = (exp_norm >= exp_ones);
  assign exp_under = exp_norm[E_WIDTH+1] || (exp_norm == '0);

  // ========================================
  // sign and special cases
  // ========================================
  logic a_nan;
  logic b_nan;
  logic a_inf;
  logic b_inf;
  logic a_zero;
  logic b_zero;
  logic out_sign;
  logic [BIT_WIDTH-1:0] result_next;

  assign a_nan  = (p.a_cls == fp_pkg::cls_nan);
  assign b_nan  = (p.b_cls == fp_pkg::cls_nan);
  assign a_inf  = (p.a_cls == fp_pkg::cls_inf);
  assign b_inf  = (p.b_cls == fp_pkg::cls_inf);
  assign a_zero = (p.a_cls == fp_pkg::cls_zero);
  assign b_zero = (p.b_cls == fp_pkg::cls_zero);

  always_comb begin
    case (sign_mode)
      fp_pkg::sign_inv: out_sign = ~p.sign;
      fp_pkg::sign_pos: out_sign = 1'b0;
      default:          out_sign = p.sign;
    endcase
  end

  // nan of a before nan of b, then infinity times zero, infinity and zero
  always_comb begin
    if (a_nan) begin
      result_next = p.a_raw;
    end else if (b_nan) begin
      result_next = p.b_raw;
    end else if ((a_inf && b_zero) || (b_inf && a_zero)) begin
      result_next = qnan_word;
    end else if (a_inf || b_inf || exp_over) begin
      result_next = {out_sign, {E_WIDTH{1'b1}}, {M_WIDTH{1'b0}}};
    end else if (a_zero || b_zero || exp_under) begin
      result_next = {out_sign, {(BIT_WIDTH-1){1'b0}}};
    end else begin
      result_next = {out_sign, exp_norm[E_WIDTH-1:0], mant_norm};
    end
  end

  // ========================================
  // output register
  // ========================================
  always_ff @(posedge clk) begin
    if (reset) begin
      result <= '0;
    end else if (load) begin
      result <= result_next;
    end
  end

  // finite operands must never turn into the quiet nan
  a_qnan_needs_special: assert property (
    @(posedge clk) disable iff (reset)
    load |=> (result != qnan_word) || $past(a_inf || b_inf || a_nan || b_nan)
  );

endmodule

`default_nettype wire

// ==== fp_mant_mul.sv ====
// stage two of the multiplier
// full significand product with the hidden bits restored, product
// sign and the exponent sum with the bias taken out once
`timescale 1ns/1ps
`default_nettype none

module fp_mant_mul #(
  parameter int BIT_WIDTH = fp_pkg::SP_BIT_WIDTH,
  parameter int E_WIDTH   = fp_pkg::SP_E_WIDTH,
  parameter int M_WIDTH   = fp_pkg::SP_M_WIDTH
) (
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire logic  load,
  fp_unpacked_if.dst u,
  fp_product_if.src  p
);

  // bias is 2^(E_WIDTH-1) - 1, widened to the sum width
  localparam logic [E_WIDTH+1:0] bias_w = {3'b000, {(E_WIDTH-1){1'b1}}};

  // ========================================
  // datapath
  // ========================================
  logic [M_WIDTH:0]           sig_a;
  logic [M_WIDTH:0]           sig_b;
  logic [2*(M_WIDTH+1)-1:0]   prod_next;
  logic signed [E_WIDTH+1:0]  exp_next;

  // hidden one, zero operands are overridden later in pack
  assign sig_a     = {1'b1, u.a_mant};
  assign sig_b     = {1'b1, u.b_mant};
  assign prod_next = sig_a * sig_b;

  // range -bias .. 2*max-bias fits with two extra bits
  assign exp_next  = $signed({2'b00, u.a_exp} + {2'b00, u.b_exp} - bias_w);

  // ========================================
  // stage register
  // ========================================
  always_ff @(posedge clk) begin
    if (reset) begin
      p.a_cls <= fp_pkg::cls_zero;
      p.b_cls <= fp_pkg::cls_zero;
    end else if (load) begin
      p.a_cls <= u.a_cls;
      p.b_cls <= u.b_cls;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      p.sign    <= u.a_sign ^ u.b_sign;
      p.exp_sum <= exp_next;
      p.prod    <= prod_next;
      p.a_raw   <= u.a_raw;
      p.b_raw   <= u.b_raw;
    end
  end

endmodule

`default_nettype wire

// ==== fp_unpack.sv ====
// stage one of the multiplier
// picks the operands, splits them into sign, exponent and mantissa,
// classifies each one and registers the lot on load
`timescale 1ns/1ps
`default_nettype none

module fp_unpack #(
  parameter int BIT_WIDTH = fp_pkg::SP_BIT_WIDTH,
  parameter int E_WIDTH   = fp_pkg::SP_E_WIDTH,
  parameter int M_WIDTH   = fp_pkg::SP_M_WIDTH
) (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic [BIT_WIDTH-1:0] a,
  input  wire logic [BIT_WIDTH-1:0] b,
  input  wire logic                 sel_square,
  input  wire logic                 load,
  fp_unpacked_if.src                u
);

  // ========================================
  // classification
  // ========================================
  // exponent zero covers zero and flushed subnormals
  function automatic fp_pkg::fp_class_e classify(
    input logic [E_WIDTH-1:0] exp_f,
    input logic [M_WIDTH-1:0] mant_f
  );
    fp_pkg::fp_class_e cls;
    if (exp_f == '0) begin
      cls = fp_pkg::cls_zero;
    end else if (exp_f == '1) begin
      cls = (mant_f == '0) ? fp_pkg::cls_inf : fp_pkg::cls_nan;
    end else begin
      cls = fp_pkg::cls_normal;
    end
    return cls;
  endfunction

  // ========================================
  // operand select and field split
  // ========================================
  logic [BIT_WIDTH-1:0] op_b;
  logic [E_WIDTH-1:0]   a_exp_f;
  logic [E_WIDTH-1:0]   b_exp_f;
  logic [M_WIDTH-1:0]   a_mant_f;
  logic [M_WIDTH-1:0]   b_mant_f;

  // square feeds a into both inputs
  assign op_b     = sel_square ? a : b;

  assign a_exp_f  = a[BIT_WIDTH-2:M_WIDTH];
  assign a_mant_f = a[M_WIDTH-1:0];
  assign b_exp_f  = op_b[BIT_WIDTH-2:M_WIDTH];
  assign b_mant_f = op_b[M_WIDTH-1:0];

  // ========================================
  // stage register
  // ========================================
  always_ff @(posedge clk) begin
    if (reset) begin
      u.a_cls <= fp_pkg::cls_zero;
      u.b_cls <= fp_pkg::cls_zero;
    end else if (load) begin
      u.a_cls <= classify(a_exp_f, a_mant_f);
      u.b_cls <= classify(b_exp_f, b_mant_f);
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      u.a_sign <= a[BIT_WIDTH-1];
      u.a_exp  <= a_exp_f;
      u.a_mant <= a_mant_f;
      u.b_sign <= op_b[BIT_WIDTH-1];
      u.b_exp  <= b_exp_f;
      u.b_mant <= b_mant_f;
      u.a_raw  <= a;
      u.b_raw  <= op_b;
    end
  end

endmodule

`default_nettype wire

// ==== fp_mul_ctrl.sv ====
// multiplier pipeline control
// decodes the opcode into operand select and sign mode, tracks which
// of the three stages hold a live operation and raises done as the
// last stage fills
`timescale 1ns/1ps
`default_nettype none

module fp_mul_ctrl (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire logic               start,
  input  wire fp_pkg::opcode_e    opcode,
  output logic                    sel_square,
  output logic                    load_s1,
  output logic                    load_s2,
  output logic                    load_s3,
  output fp_pkg::sign_mode_e      sign_mode,
  output logic                    done
);

  // ========================================
  // opcode decode
  // ========================================
  fp_pkg::sign_mode_e sign_mode_dec;

  always_comb begin
    case (opcode)
      fp_pkg::op_neg_mul: sign_mode_dec = fp_pkg::sign_inv;
      fp_pkg::op_abs_mul: sign_mode_dec = fp_pkg::sign_pos;
      // square keeps the product sign, always positive anyway
      default:            sign_mode_dec = fp_pkg::sign_xor;
    endcase
  end

  // b is replaced by a only for the square opcode
  assign sel_square = (opcode == fp_pkg::op_square);

  // ========================================
  // stage tracking
  // ========================================
  // bit i set means stage i+1 took an operation last cycle
  logic [2:0] valid_q;
  // sign mode rides two cycles to meet stage three
  fp_pkg::sign_mode_e sign_mode_s1;
  fp_pkg::sign_mode_e sign_mode_s2;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q      <= 3'b000;
      sign_mode_s1 <= fp_pkg::sign_xor;
      sign_mode_s2 <= fp_pkg::sign_xor;
    end else begin
      valid_q      <= {valid_q[1:0], start};
      sign_mode_s1 <= sign_mode_dec;
      sign_mode_s2 <= sign_mode_s1;
    end
  end

  // stage one captures on the start cycle itself
  assign load_s1   = start;
  assign load_s2   = valid_q[0];
  assign load_s3   = valid_q[1];
  assign sign_mode = sign_mode_s2;
  // result register updates together with this bit
  assign done      = valid_q[2];

  // no stale done may leak out of a reset
  a_no_done_after_reset: assert property (
    @(posedge clk) reset |=> !done
  );

endmodule

`default_nettype wire

// ==== fp_stage_if.sv ====
// stage interfaces of the pipelined multiplier
// fp_unpacked_if carries split and classified operands into stage two,
// fp_product_if carries the raw significand product into stage three
`timescale 1ns/1ps
`default_nettype none

interface fp_unpacked_if #(
  parameter int BIT_WIDTH = fp_pkg::SP_BIT_WIDTH,
  parameter int E_WIDTH   = fp_pkg::SP_E_WIDTH,
  parameter int M_WIDTH   = fp_pkg::SP_M_WIDTH
);
  // operand a fields
  logic                   a_sign;
  logic [E_WIDTH-1:0]     a_exp;
  logic [M_WIDTH-1:0]     a_mant;
  fp_pkg::fp_class_e      a_cls;
  // operand b fields
  logic                   b_sign;
  logic [E_WIDTH-1:0]     b_exp;
  logic [M_WIDTH-1:0]     b_mant;
  fp_pkg::fp_class_e      b_cls;
  // raw words kept for nan pass-through
  logic [BIT_WIDTH-1:0]   a_raw;
  logic [BIT_WIDTH-1:0]   b_raw;

  modport src (output a_sign, a_exp, a_mant, a_cls, b_sign, b_exp, b_mant, b_cls,
               a_raw, b_raw);
  modport dst (input  a_sign, a_exp, a_mant, a_cls, b_sign, b_exp, b_mant, b_cls,
               a_raw, b_raw);
endinterface

interface fp_product_if #(
  parameter int BIT_WIDTH = fp_pkg::SP_BIT_WIDTH,
  parameter int E_WIDTH   = fp_pkg::SP_E_WIDTH,
  parameter int M_WIDTH   = fp_pkg::SP_M_WIDTH
);
  logic                        sign;
  // biased sum, two extra bits for overflow and a sign
  logic signed [E_WIDTH+1:0]   exp_sum;
  logic [2*(M_WIDTH+1)-1:0]    prod;
  fp_pkg::fp_class_e           a_cls;
  fp_pkg::fp_class_e           b_cls;
  logic [BIT_WIDTH-1:0]        a_raw;
  logic [BIT_WIDTH-1:0]        b_raw;

  modport src (output sign, exp_sum, prod, a_cls, b_cls, a_raw, b_raw);
  modport dst (input  sign, exp_sum, prod, a_cls, b_cls, a_raw, b_raw);
endinterface

`default_nettype wire

// ==== fp_pkg.sv ====
// floating-point multiply package
// opcode, sign mode and operand class enums plus the default
// single-precision format constants shared by the datapath and the model
`default_nettype none

package fp_pkg;

  // ========================================
  // format constants
  // ========================================
  // default operand format, single precision
  parameter int SP_BIT_WIDTH = 32;
  parameter int SP_E_WIDTH   = 8;
  parameter int SP_M_WIDTH   = 23;

  // canonical quiet nan returned for infinity times zero
  parameter logic [31:0] QNAN = 32'h7fc00000;

  // ========================================
  // enums
  // ========================================
  // operations accepted on the start strobe
  typedef enum logic [1:0] {
    op_mul     = 2'd0,
    op_square  = 2'd1,
    op_neg_mul = 2'd2,
    op_abs_mul = 2'd3
  } opcode_e;

  // how the final sign is formed in the pack stage
  typedef enum logic [1:0] {
    sign_xor = 2'd0,
    sign_inv = 2'd1,
    sign_pos = 2'd2
  } sign_mode_e;

  // operand classes, subnormals land in cls_zero
  typedef enum logic [1:0] {
    cls_zero   = 2'd0,
    cls_normal = 2'd1,
    cls_inf    = 2'd2,
    cls_nan    = 2'd3
  } fp_class_e;

endpackage

`default_nettype wire
